// File: source/gb_cpu_params.svh
`ifndef GB_CPU_PARAMS_SVH
`define GB_CPU_PARAMS_SVH

`default_nettype none

// Host bus widths
`define GB_WB_ADDR_W 5
`define GB_WB_DATA_W 32

// Writes here execute one command
// Reads below 15 return a register byte
`define GB_CMD_ADDR 16

// Post-boot register contents
`define GB_RESET_A   8'h01
`define GB_RESET_F   8'hB0
`define GB_RESET_B   8'h00
`define GB_RESET_C   8'h13
`define GB_RESET_D   8'h00
`define GB_RESET_E   8'hD8
`define GB_RESET_H   8'h01
`define GB_RESET_L   8'h4D
`define GB_RESET_SP  16'hFFFE
`define GB_RESET_PC  16'h0100
`define GB_RESET_TMP 16'h0000
`define GB_RESET_IR  8'h00

`default_nettype wire

`endif

// File: source/gb_cpu_common_pkg.sv
`default_nettype none

package gb_cpu_common_pkg;

    // Byte register index, doubles as the readback address
    typedef logic [3:0] regfile_r8_t;

    localparam regfile_r8_t REG_IR    = 4'd0;
    localparam regfile_r8_t REG_A     = 4'd1;
    localparam regfile_r8_t REG_F     = 4'd2;
    localparam regfile_r8_t REG_B     = 4'd3;
    localparam regfile_r8_t REG_C     = 4'd4;
    localparam regfile_r8_t REG_D     = 4'd5;
    localparam regfile_r8_t REG_E     = 4'd6;
    localparam regfile_r8_t REG_H     = 4'd7;
    localparam regfile_r8_t REG_L     = 4'd8;
    localparam regfile_r8_t REG_SP_H  = 4'd9;
    localparam regfile_r8_t REG_SP_L  = 4'd10;
    localparam regfile_r8_t REG_PC_H  = 4'd11;
    localparam regfile_r8_t REG_PC_L  = 4'd12;
    localparam regfile_r8_t REG_TMP_H = 4'd13;
    localparam regfile_r8_t REG_TMP_L = 4'd14;
    // Matches no register
    localparam regfile_r8_t REG_NONE  = 4'd15;

    // Register pair index
    typedef logic [2:0] regfile_r16_t;

    localparam regfile_r16_t REG_AF  = 3'd0;
    localparam regfile_r16_t REG_BC  = 3'd1;
    localparam regfile_r16_t REG_DE  = 3'd2;
    localparam regfile_r16_t REG_HL  = 3'd3;
    localparam regfile_r16_t REG_SP  = 3'd4;
    localparam regfile_r16_t REG_PC  = 3'd5;
    localparam regfile_r16_t REG_TMP = 3'd6;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // Field order follows the index codes, IR in the top byte
    typedef struct packed {
        byte_t ir;
        byte_t a;
        byte_t f;
        byte_t b;
        byte_t c;
        byte_t d;
        byte_t e;
        byte_t h;
        byte_t l;
        byte_t sp_hi;
        byte_t sp_lo;
        byte_t pc_hi;
        byte_t pc_lo;
        byte_t tmp_hi;
        byte_t tmp_lo;
    } regfile_t;

    // Same bit order as the upper nibble of F
    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } alu_flags_t;

    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_ADC = 3'd1;
    localparam alu_op_t ALU_SUB = 3'd2;
    localparam alu_op_t ALU_SBC = 3'd3;
    localparam alu_op_t ALU_AND = 3'd4;
    localparam alu_op_t ALU_XOR = 3'd5;
    localparam alu_op_t ALU_OR  = 3'd6;
    localparam alu_op_t ALU_CP  = 3'd7;

    typedef logic [2:0] cmd_op_t;

    localparam cmd_op_t CMD_ALU        = 3'd0;
    localparam cmd_op_t CMD_INC16      = 3'd1;
    localparam cmd_op_t CMD_DEC16      = 3'd2;
    localparam cmd_op_t CMD_LOAD       = 3'd3;
    localparam cmd_op_t CMD_OVERWRITE  = 3'd4;
    localparam cmd_op_t CMD_SET_ADJ    = 3'd5;
    localparam cmd_op_t CMD_ADD_ADJ_PC = 3'd6;
    localparam cmd_op_t CMD_NOP        = 3'd7;

    // Command word as carried on the bus write data
    typedef struct packed {
        logic [4:0]  rsvd_top;
        cmd_op_t     op;
        logic        rsvd_op;
        alu_op_t     alu_op;
        regfile_r8_t src;
        logic [3:0]  rsvd_mid;
        logic [3:0]  dst;
        byte_t       data;
    } host_cmd_t;

    function automatic regfile_r8_t getRegisterLow(regfile_r16_t r16);
        case (r16)
            REG_AF:  return REG_F;
            REG_BC:  return REG_C;
            REG_DE:  return REG_E;
            REG_HL:  return REG_L;
            REG_SP:  return REG_SP_L;
            REG_PC:  return REG_PC_L;
            REG_TMP: return REG_TMP_L;
            default: return REG_NONE;
        endcase
    endfunction

    function automatic regfile_r8_t getRegisterHigh(regfile_r16_t r16);
        case (r16)
            REG_AF:  return REG_A;
            REG_BC:  return REG_B;
            REG_DE:  return REG_D;
            REG_HL:  return REG_H;
            REG_SP:  return REG_SP_H;
            REG_PC:  return REG_PC_H;
            REG_TMP: return REG_TMP_H;
            default: return REG_NONE;
        endcase
    endfunction

    // Byte read by index, unknown codes read as zero
    function automatic byte_t read_r8(regfile_t regs, regfile_r8_t idx);
        case (idx)
            REG_IR:    return regs.ir;
            REG_A:     return regs.a;
            REG_F:     return regs.f;
            REG_B:     return regs.b;
            REG_C:     return regs.c;
            REG_D:     return regs.d;
            REG_E:     return regs.e;
            REG_H:     return regs.h;
            REG_L:     return regs.l;
            REG_SP_H:  return regs.sp_hi;
            REG_SP_L:  return regs.sp_lo;
            REG_PC_H:  return regs.pc_hi;
            REG_PC_L:  return regs.pc_lo;
            REG_TMP_H: return regs.tmp_hi;
            REG_TMP_L: return regs.tmp_lo;
            default:   return 8'h00;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: source/gb_cpu_alu.sv
`default_nettype none

module gb_cpu_alu
    import gb_cpu_common_pkg::*;
(
    input  regfile_t    registers,
    input  alu_op_t     alu_op,
    input  regfile_r8_t alu_src,
    output byte_t       alu_data,
    output alu_flags_t  alu_flags
);

    byte_t      operand;
    byte_t      result;
    logic       carry_in;
    logic [8:0] full;
    logic [4:0] half;

    assign operand = read_r8(registers, alu_src);

    // Old carry sits in F bit 4, used only by the with-carry forms
    assign carry_in = (alu_op == ALU_ADC || alu_op == ALU_SBC) ? registers.f[4] : 1'b0;

    always_comb begin
        full = '0;
        half = '0;
        result = '0;
        alu_flags = '0;
        case (alu_op)
            ALU_ADD, ALU_ADC: begin
                full = {1'b0, registers.a} + {1'b0, operand} + {8'h00, carry_in};
                half = {1'b0, registers.a[3:0]} + {1'b0, operand[3:0]} + {4'h0, carry_in};
                result = full[7:0];
                alu_flags.h = half[4];
                alu_flags.c = full[8];
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                // Borrow shows up as the wrapped top bit
                full = {1'b0, registers.a} - {1'b0, operand} - {8'h00, carry_in};
                half = {1'b0, registers.a[3:0]} - {1'b0, operand[3:0]} - {4'h0, carry_in};
                result = full[7:0];
                alu_flags.n = 1'b1;
                alu_flags.h = half[4];
                alu_flags.c = full[8];
            end
            ALU_AND: begin
                result = registers.a & operand;
                alu_flags.h = 1'b1;
            end
            ALU_XOR: result = registers.a ^ operand;
            ALU_OR:  result = registers.a | operand;
            default: ;
        endcase
        alu_flags.z = (result == 8'h00);
    end

    // Compare keeps A, only its flags count
    assign alu_data = (alu_op == ALU_CP) ? registers.a : result;

endmodule

`default_nettype wire

// File: source/gb_cpu_regfile.sv
`include "gb_cpu_params.svh"
`default_nettype none

module gb_cpu_regfile
    import gb_cpu_common_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         alu_wren,
    input  regfile_r16_t idu_req,
    input  word_t        idu_data,
    input  logic         idu_wren,
    input  regfile_r8_t  data_bus_req,
    input  byte_t        data_bus_data,
    input  logic         data_bus_wren,
    input  regfile_r16_t overwrite_req,
    input  logic         overwrite_wren,
    input  logic         set_adj,
    input  logic         add_adj_pc,
    input  byte_t        alu_data,
    input  alu_flags_t   alu_flags,
    output regfile_t     registers
);

    regfile_t regs_next;
    word_t    jump_target;

    // Byte write by index
    // F is skipped here, flags come from the ALU path only
    function automatic regfile_t write_r8(regfile_t regs, regfile_r8_t idx, byte_t value);
        regfile_t result;
        result = regs;
        case (idx)
            REG_IR:    result.ir = value;
            REG_A:     result.a = value;
            REG_B:     result.b = value;
            REG_C:     result.c = value;
            REG_D:     result.d = value;
            REG_E:     result.e = value;
            REG_H:     result.h = value;
            REG_L:     result.l = value;
            REG_SP_H:  result.sp_hi = value;
            REG_SP_L:  result.sp_lo = value;
            REG_PC_H:  result.pc_hi = value;
            REG_PC_L:  result.pc_lo = value;
            REG_TMP_H: result.tmp_hi = value;
            REG_TMP_L: result.tmp_lo = value;
            default: ;
        endcase
        return result;
    endfunction

    // Relative jump target, wraps at 16 bits
    assign jump_target = {registers.pc_hi, registers.pc_lo}
                       + {registers.tmp_hi, registers.tmp_lo};

    // One command at a time, so at most one source is live
    always_comb begin
        regs_next = registers;
        if (alu_wren) begin
            // Compare returns A unchanged, so only the flags move
            regs_next.a = alu_data;
            regs_next.f = {alu_flags, 4'h0};
        end else if (idu_wren) begin
            regs_next = write_r8(regs_next, getRegisterHigh(idu_req), idu_data[15:8]);
            regs_next = write_r8(regs_next, getRegisterLow(idu_req), idu_data[7:0]);
        end else if (data_bus_wren) begin
            // Bus loads land only in IR or TMP
            if (data_bus_req inside {REG_IR, REG_TMP_H, REG_TMP_L}) begin
                regs_next = write_r8(regs_next, data_bus_req, data_bus_data);
            end
        end else if (overwrite_wren) begin
            regs_next = write_r8(regs_next, getRegisterHigh(overwrite_req), registers.tmp_hi);
            regs_next = write_r8(regs_next, getRegisterLow(overwrite_req), registers.tmp_lo);
        end else if (set_adj) begin
            // Sign extend the offset byte
            regs_next.tmp_hi = {8{registers.tmp_lo[7]}};
        end else if (add_adj_pc) begin
            {regs_next.tmp_hi, regs_next.tmp_lo} = jump_target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            registers.ir <= `GB_RESET_IR;
            registers.a <= `GB_RESET_A;
            registers.f <= `GB_RESET_F;
            registers.b <= `GB_RESET_B;
            registers.c <= `GB_RESET_C;
            registers.d <= `GB_RESET_D;
            registers.e <= `GB_RESET_E;
            registers.h <= `GB_RESET_H;
            registers.l <= `GB_RESET_L;
            {registers.sp_hi, registers.sp_lo} <= `GB_RESET_SP;
            {registers.pc_hi, registers.pc_lo} <= `GB_RESET_PC;
            {registers.tmp_hi, registers.tmp_lo} <= `GB_RESET_TMP;
        end else begin
            registers <= regs_next;
        end
    end

endmodule

`default_nettype wire

// File: source/gb_cpu_host_port.sv
`include "gb_cpu_params.svh"
`default_nettype none

module gb_cpu_host_port
    import gb_cpu_common_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`GB_WB_ADDR_W-1:0] adr,
    input  logic [`GB_WB_DATA_W-1:0] dat_w,
    output logic [`GB_WB_DATA_W-1:0] dat_r,
    output logic                     ack,
    input  regfile_t                 registers,
    output logic                     alu_wren,
    output regfile_r16_t             idu_req,
    output word_t                    idu_data,
    output logic                     idu_wren,
    output regfile_r8_t              data_bus_req,
    output byte_t                    data_bus_data,
    output logic                     data_bus_wren,
    output regfile_r16_t             overwrite_req,
    output logic                     overwrite_wren,
    output logic                     set_adj,
    output logic                     add_adj_pc,
    output alu_op_t                  alu_op,
    output regfile_r8_t              alu_src
);

    // Readable bytes sit at addresses 0 to 14
    localparam int unsigned NUM_R8 = 15;

    host_cmd_t cmd;
    logic      request;
    logic      cmd_write;
    word_t     pair_value;
    byte_t     read_byte;

    // Request not yet acknowledged, so each cycle gets one ack
    assign request = cyc & stb & ~ack;
    assign cmd_write = request & we & (adr == `GB_WB_ADDR_W'(`GB_CMD_ADDR));
    assign cmd = host_cmd_t'(dat_w);

    // One strobe per command, high only in the acknowledging cycle
    assign alu_wren = cmd_write && (cmd.op == CMD_ALU);
    assign idu_wren = cmd_write && (cmd.op == CMD_INC16 || cmd.op == CMD_DEC16);
    assign data_bus_wren = cmd_write && (cmd.op == CMD_LOAD);
    assign overwrite_wren = cmd_write && (cmd.op == CMD_OVERWRITE);
    assign set_adj = cmd_write && (cmd.op == CMD_SET_ADJ);
    assign add_adj_pc = cmd_write && (cmd.op == CMD_ADD_ADJ_PC);

    // Operand fields pass straight through
    assign alu_op = cmd.alu_op;
    assign alu_src = cmd.src;
    assign idu_req = cmd.dst[2:0];
    assign overwrite_req = cmd.dst[2:0];
    assign data_bus_req = cmd.dst;
    assign data_bus_data = cmd.data;

    // IDU, plus or minus one with 16-bit wrap
    assign pair_value = {read_r8(registers, getRegisterHigh(idu_req)),
                         read_r8(registers, getRegisterLow(idu_req))};
    assign idu_data = (cmd.op == CMD_DEC16) ? pair_value - 16'd1 : pair_value + 16'd1;

    assign read_byte = read_r8(registers, adr[3:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= request;
        end
    end

    // Readback registered alongside ack
    // Writes and unmapped reads return zero
    always_ff @(posedge clk) begin
        if (request && !we && adr < `GB_WB_ADDR_W'(NUM_R8)) begin
            dat_r <= {{(`GB_WB_DATA_W - 8){1'b0}}, read_byte};
        end else begin
            dat_r <= '0;
        end
    end

endmodule

`default_nettype wire

// File: source/gb_cpu_datapath.sv
`include "gb_cpu_params.svh"
`default_nettype none

module gb_cpu_datapath
    import gb_cpu_common_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`GB_WB_ADDR_W-1:0] adr,
    input  logic [`GB_WB_DATA_W-1:0] dat_w,
    output logic [`GB_WB_DATA_W-1:0] dat_r,
    output logic                     ack
);

    // Register state shared by the port and the ALU
    regfile_t registers;

    // Write request bundle from the port
    logic         alu_wren;
    regfile_r16_t idu_req;
    word_t        idu_data;
    logic         idu_wren;
    regfile_r8_t  data_bus_req;
    byte_t        data_bus_data;
    logic         data_bus_wren;
    regfile_r16_t overwrite_req;
    logic         overwrite_wren;
    logic         set_adj;
    logic         add_adj_pc;

    // ALU control and result
    alu_op_t     alu_op;
    regfile_r8_t alu_src;
    byte_t       alu_data;
    alu_flags_t  alu_flags;

    // Port names match the nets, so connect by name
    gb_cpu_host_port host_port_i (.*);

    gb_cpu_regfile regfile_i (.*);

    gb_cpu_alu alu_i (.*);

endmodule

`default_nettype wire

// File: sim/gb_cpu_datapath_checker.sv
`default_nettype none

module gb_cpu_datapath_checker
    import gb_cpu_common_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  cyc,
    input logic  stb,
    input logic  ack,
    input byte_t f
);
    timeunit 1ns;
    timeprecision 1ps;

    // Count of assertion failures
    int fail_count = 0;

    // Ack only answers an open request
    ack_in_request: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
        else begin
            fail_count = fail_count + 1;
            $error("ack high without cyc and stb");
        end

    // Single cycle ack pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else begin
            fail_count = fail_count + 1;
            $error("ack high for two cycles in a row");
        end

    // Lower flag nibble never holds anything
    flags_low_zero: assert property (@(posedge clk) disable iff (reset) f[3:0] == 4'h0)
        else begin
            fail_count = fail_count + 1;
            $error("F low nibble is 0x%0h", f[3:0]);
        end

    ack_after_reset: assert property (@(posedge clk) reset |=> !ack)
        else begin
            fail_count = fail_count + 1;
            $error("ack high in the cycle after reset");
        end

endmodule

`default_nettype wire

// File: sim/gb_cpu_datapath_tb.sv
`include "gb_cpu_params.svh"
`default_nettype none

module gb_cpu_datapath_tb
    import gb_cpu_common_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // About 740 bus transfers of 3 clocks each plus reset, with headroom
    localparam int TIMEOUT_CYCLES = 4000;

    // Byte indices of each pair, AF BC DE HL SP PC TMP
    localparam int PAIR_HI [7] = '{1, 3, 5, 7, 9, 11, 13};
    localparam int PAIR_LO [7] = '{2, 4, 6, 8, 10, 12, 14};

    logic                     clk;
    logic                     reset;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`GB_WB_ADDR_W-1:0] adr;
    logic [`GB_WB_DATA_W-1:0] dat_w;
    logic [`GB_WB_DATA_W-1:0] dat_r;
    logic                     ack;

    // Expected register bytes, indexed like the readback addresses
    byte_t       model [15];
    string       reg_name [15] = '{"IR", "A", "F", "B", "C", "D", "E", "H", "L",
                                   "SP_H", "SP_L", "PC_H", "PC_L", "TMP_H", "TMP_L"};
    logic [31:0] rng = 32'h5eef;
    int          cycle_count = 0;
    int          ack_count = 0;
    int          txn_count = 0;

    gb_cpu_datapath gb_cpu_datapath_i (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack(ack)
    );

    bind gb_cpu_datapath gb_cpu_datapath_checker checker_i (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .ack(ack),
        .f(registers.f)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: test still running after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // Pre-edge ack value, one count per pulse cycle
    always @(posedge clk) begin
        if (!reset && ack) begin
            ack_count++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Command word, layout op 26:24, alu 22:20, src 19:16, dst 11:8, data 7:0
    function automatic logic [31:0] make_cmd(input cmd_op_t op, input alu_op_t aop,
                                             input regfile_r8_t src, input logic [3:0] dst,
                                             input byte_t data);
        return {5'b0, op, 1'b0, aop, src, 4'b0, dst, data};
    endfunction

    // Expected {A, F} after one ALU operation
    function automatic logic [15:0] alu_expect(input alu_op_t op, input byte_t a,
                                               input byte_t b, input byte_t f_old);
        int    ra;
        int    rb;
        int    cin;
        int    r;
        byte_t res;
        logic  n;
        logic  h;
        logic  c;
        ra = int'(a);
        rb = int'(b);
        cin = (op == ALU_ADC || op == ALU_SBC) ? int'(f_old[4]) : 0;
        r = 0;
        n = 1'b0;
        h = 1'b0;
        c = 1'b0;
        case (op)
            ALU_ADD, ALU_ADC: begin
                r = ra + rb + cin;
                h = ((ra % 16) + (rb % 16) + cin) > 15;
                c = r > 255;
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                // Borrow whenever the subtrahend is larger
                r = ra - rb - cin;
                n = 1'b1;
                h = (ra % 16) < ((rb % 16) + cin);
                c = ra < (rb + cin);
            end
            ALU_AND: begin
                r = ra & rb;
                h = 1'b1;
            end
            ALU_XOR: r = ra ^ rb;
            default: r = ra | rb;
        endcase
        res = r[7:0];
        return {(op == ALU_CP) ? a : res, (res == 8'h00), n, h, c, 4'h0};
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got === expected) else begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wb_write(input logic [`GB_WB_ADDR_W-1:0] a, input logic [31:0] d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        adr <= a;
        dat_w <= d;
        @(posedge clk);
        while (!ack) @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        txn_count++;
        // Write cycles carry no read data
        expect_value("dat_r", dat_r, 32'h0);
    endtask

    task automatic wb_read(input logic [`GB_WB_ADDR_W-1:0] a, output logic [31:0] d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b0;
        adr <= a;
        @(posedge clk);
        while (!ack) @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        txn_count++;
        d = dat_r;
    endtask

    task automatic load_byte(input regfile_r8_t dst, input byte_t val);
        wb_write(`GB_CMD_ADDR, make_cmd(CMD_LOAD, ALU_ADD, REG_IR, dst, val));
        model[dst] = val;
    endtask

    // F keeps its value, only ALU commands touch it
    task automatic overwrite_pair(input regfile_r16_t p);
        wb_write(`GB_CMD_ADDR, make_cmd(CMD_OVERWRITE, ALU_ADD, REG_IR, {1'b0, p}, 8'h00));
        model[PAIR_HI[p]] = model[REG_TMP_H];
        if (p != REG_AF) begin
            model[PAIR_LO[p]] = model[REG_TMP_L];
        end
    endtask

    task automatic set_pair(input regfile_r16_t p, input word_t v);
        load_byte(REG_TMP_H, v[15:8]);
        load_byte(REG_TMP_L, v[7:0]);
        overwrite_pair(p);
    endtask

    task automatic step_idu(input cmd_op_t op, input regfile_r16_t p);
        word_t v;
        v = {model[PAIR_HI[p]], model[PAIR_LO[p]]};
        v = (op == CMD_INC16) ? v + 16'd1 : v - 16'd1;
        wb_write(`GB_CMD_ADDR, make_cmd(op, ALU_ADD, REG_IR, {1'b0, p}, 8'h00));
        model[PAIR_HI[p]] = v[15:8];
        model[PAIR_LO[p]] = v[7:0];
    endtask

    task automatic run_alu(input alu_op_t aop, input regfile_r8_t src);
        logic [15:0] res;
        res = alu_expect(aop, model[REG_A], model[src], model[REG_F]);
        wb_write(`GB_CMD_ADDR, make_cmd(CMD_ALU, aop, src, 4'h0, 8'h00));
        model[REG_A] = res[15:8];
        model[REG_F] = res[7:0];
    endtask

    task automatic check_reg(input regfile_r8_t idx);
        logic [31:0] d;
        wb_read(idx, d);
        expect_value(reg_name[idx], d, {24'h0, model[idx]});
    endtask

    task automatic check_all();
        for (int r = 0; r < 15; r++) begin
            check_reg(4'(r));
        end
    endtask

    initial begin
        logic [31:0] d;
        word_t       v;
        word_t       target;
        byte_t       off;
        alu_op_t     aop;
        regfile_r16_t p;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        reset = 1'b1;
        // Post-boot contents
        model = '{8'h00, 8'h01, 8'hB0, 8'h00, 8'h13, 8'h00, 8'hD8, 8'h01, 8'h4D,
                  8'hFF, 8'hFE, 8'h01, 8'h00, 8'h00, 8'h00};
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        check_all();

        // ALU with random A and a random source, all eight codes in the first pass
        for (int i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            set_pair(REG_AF, rng[15:0]);
            set_pair(3'(1 + i % 3), rng[31:16]);
            rng = xorshift32(rng);
            aop = (i < 8) ? 3'(i) : rng[6:4];
            run_alu(aop, 4'(rng % 32'd15));
            check_reg(REG_A);
            check_reg(REG_F);
        end

        // IDU on every pair but AF, wrap and byte carry corners first
        for (int q = 1; q < 7; q++) begin
            for (int k = 0; k < 4; k++) begin
                rng = xorshift32(rng);
                v = (k == 0) ? 16'hFFFF : (k == 1) ? 16'h00FF : (k == 2) ? 16'h0000 : rng[15:0];
                p = 3'(q);
                set_pair(p, v);
                step_idu(CMD_INC16, p);
                check_reg(4'(PAIR_HI[p]));
                check_reg(4'(PAIR_LO[p]));
                step_idu(CMD_DEC16, p);
                step_idu(CMD_DEC16, p);
                check_reg(4'(PAIR_HI[p]));
                check_reg(4'(PAIR_LO[p]));
            end
        end

        // TMP copied into BC DE HL SP PC
        for (int q = 1; q < 6; q++) begin
            rng = xorshift32(rng);
            set_pair(3'(q), rng[15:0]);
            check_reg(4'(PAIR_HI[q]));
            check_reg(4'(PAIR_LO[q]));
        end
        rng = xorshift32(rng);
        load_byte(REG_IR, rng[7:0]);
        check_reg(REG_IR);

        // Relative jump, positive and negative offsets
        for (int k = 0; k < 5; k++) begin
            rng = xorshift32(rng);
            off = (k == 0) ? 8'h05 : (k == 1) ? 8'h7F : (k == 2) ? 8'h80 :
                  (k == 3) ? 8'hFE : rng[23:16];
            set_pair(REG_PC, rng[15:0]);
            load_byte(REG_TMP_L, off);
            wb_write(`GB_CMD_ADDR, make_cmd(CMD_SET_ADJ, ALU_ADD, REG_IR, 4'h0, 8'h00));
            model[REG_TMP_H] = off[7] ? 8'hFF : 8'h00;
            check_reg(REG_TMP_H);
            target = rng[15:0] + 16'($signed(off));
            wb_write(`GB_CMD_ADDR, make_cmd(CMD_ADD_ADJ_PC, ALU_ADD, REG_IR, 4'h0, 8'h00));
            model[REG_TMP_H] = target[15:8];
            model[REG_TMP_L] = target[7:0];
            wb_read(REG_TMP_H, d);
            v[15:8] = d[7:0];
            wb_read(REG_TMP_L, d);
            v[7:0] = d[7:0];
            expect_value("TMP", {16'h0, v}, {16'h0, target});
        end

        // Loads sent to other addresses must do nothing
        for (int a = 0; a < 32; a++) begin
            if (a != `GB_CMD_ADDR) begin
                wb_write(5'(a), make_cmd(CMD_LOAD, ALU_ADD, REG_IR, REG_IR, ~model[REG_IR]));
            end
        end
        check_all();
        // Unmapped reads return zero
        for (int a = 15; a < 32; a += 4) begin
            wb_read(5'(a), d);
            expect_value("dat_r", d, 32'h0);
        end

        repeat (2) @(posedge clk);
        if (ack_count == txn_count && gb_cpu_datapath_i.checker_i.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Saw %0d ack pulses for %0d transfers and %0d assertion failures",
                     ack_count, txn_count, gb_cpu_datapath_i.checker_i.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "end of test checks failed");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/gb_cpu_common_pkg.sv
source/gb_cpu_alu.sv
source/gb_cpu_regfile.sv
source/gb_cpu_host_port.sv
source/gb_cpu_datapath.sv
sim/gb_cpu_datapath_checker.sv
sim/gb_cpu_datapath_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps -Wall -Wno-fatal
TOP        = gb_cpu_datapath_tb
FILELIST   = tb.f
OBJ_DIR    = obj_dir
RUN_ARGS   = +verilator+error+limit+100
PASS_MSG   = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
